// ==== hw/issue_params.svh ====
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

////////////////////////////////////////////////////////////
// Core sizing
////////////////////////////////////////////////////////////

// Warps sharing the issue slice
`define NUM_WARPS 4

// Operand and result width
`define DATA_W 16

// Words in the MEM scratch memory
`define MEM_DEPTH 16

// MEM pipe depth, issue stage included (3 to 6)
`define NUM_MEM_STAGES 4

`endif

// ==== hw/issue_pkg.sv ====
`include "issue_params.svh"

////////////////////////////////////////////////////////////
// Scheduling types
////////////////////////////////////////////////////////////

package issue_pkg;

    // One request or grant bit per warp
    // Bit i belongs to warp i
    typedef logic [`NUM_WARPS-1:0] warp_mask_t;

    // Warp number as carried on the issue and result paths
    // Sized from the warp count
    typedef logic [$clog2(`NUM_WARPS)-1:0] warp_idx_t;

endpackage

// ==== hw/exec_pkg.sv ====
`include "issue_params.svh"

////////////////////////////////////////////////////////////
// Execution types
////////////////////////////////////////////////////////////

package exec_pkg;

    // Single operand or result word
    typedef logic [`DATA_W-1:0] data_t;

    // Scratch memory word address
    // Taken from the low bits of operand A
    typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_addr_t;

    // Operands of all warps side by side
    // Warp i occupies bits [i*DATA_W +: DATA_W]
    typedef logic [`NUM_WARPS*`DATA_W-1:0] operand_bus_t;

endpackage

// ==== hw/issue_if.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// One issued instruction, scheduler to execute pipe
interface issue_if;

    // One-cycle strobe per issued instruction
    logic                  valid;
    // Issuing warp
    issue_pkg::warp_idx_t  warp;
    // Instruction writes a register
    logic                  reg_write;
    // Operands of the issuing warp
    exec_pkg::data_t       opnd_a;
    exec_pkg::data_t       opnd_b;

    // Scheduler side
    modport issuer (
        output valid,
        output warp,
        output reg_write,
        output opnd_a,
        output opnd_b
    );

    // Execute pipe side
    modport executor (
        input valid,
        input warp,
        input reg_write,
        input opnd_a,
        input opnd_b
    );

endinterface

// ==== hw/rr_prioritizer.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// Round-robin arbiter, one-hot grant in the request cycle
module rr_prioritizer #(
    parameter int WIDTH = `NUM_WARPS
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grt
);

    // Priority pointer as a thermometer mask
    // Bits at and above the pointer are set
    logic [WIDTH-1:0] prio_mask;

    // Requests inside the priority window
    logic [WIDTH-1:0] req_masked;

    // Lowest set bit, windowed and unwindowed
    logic [WIDTH-1:0] grt_masked;
    logic [WIDTH-1:0] grt_any;

    assign req_masked = req & prio_mask;

    // Two's complement trick isolates the lowest set bit
    assign grt_masked = req_masked & (~req_masked + 1'b1);
    assign grt_any    = req & (~req + 1'b1);

    // Nothing at or above the pointer, wrap to the bottom
    assign grt = (|req_masked) ? grt_masked : grt_any;

    ////////////////////////////////////////////////////////////
    // Pointer update
    ////////////////////////////////////////////////////////////

    // Window moves to the warp after the winner
    // Top warp winning leaves an empty window, same as pointer 0
    always_ff @(posedge clk) begin
        if (!rst) begin
            prio_mask <= '1;
        end else if (|grt) begin
            prio_mask <= ~(grt | (grt - 1'b1));
        end
    end

endmodule

// ==== hw/cdb_scheduler.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// Issue scheduler for the ALU and MEM pipes sharing one CDB
// Non-writing instructions never reach the CDB and are never held back
module cdb_scheduler (
    input  logic                    clk,
    input  logic                    rst,
    input  issue_pkg::warp_mask_t   alu_req,
    input  issue_pkg::warp_mask_t   mem_req,
    input  issue_pkg::warp_mask_t   reg_write,
    input  exec_pkg::operand_bus_t  opnd_a,
    input  exec_pkg::operand_bus_t  opnd_b,
    output issue_pkg::warp_mask_t   alu_grt,
    output issue_pkg::warp_mask_t   mem_grt,
    issue_if.issuer                 alu_issue,
    issue_if.issuer                 mem_issue
);

    // One bit per MEM stage behind issue
    localparam int HIST_W = `NUM_MEM_STAGES - 1;

    logic [HIST_W-1:0]      load_hist;
    logic                   load_in;
    logic                   alu_wr_waiting;
    issue_pkg::warp_mask_t  alu_req_q;
    issue_pkg::warp_mask_t  mem_req_q;
    issue_pkg::warp_idx_t   alu_idx;
    issue_pkg::warp_idx_t   mem_idx;

    // One-hot grant to warp number
    function automatic issue_pkg::warp_idx_t onehot_to_idx(
        input issue_pkg::warp_mask_t oh
    );
        issue_pkg::warp_idx_t idx;
        idx = '0;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            if (oh[i]) begin
                idx = issue_pkg::warp_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // Operand slice of one warp
    function automatic exec_pkg::data_t pick_operand(
        input exec_pkg::operand_bus_t bus,
        input issue_pkg::warp_idx_t   idx
    );
        return bus[idx*`DATA_W +: `DATA_W];
    endfunction

    ////////////////////////////////////////////////////////////
    // Load history and request qualification
    ////////////////////////////////////////////////////////////

    // Granted MEM op this cycle is a load
    assign load_in = |(mem_grt & reg_write);

    // Oldest bit is a load reaching the CDB with an ALU write issued now
    always_ff @(posedge clk) begin
        if (!rst) begin
            load_hist <= '0;
        end else begin
            load_hist <= {load_hist[HIST_W-2:0], load_in};
        end
    end

    // Block ALU register writes only, branches pass
    assign alu_req_q = load_hist[HIST_W-1] ? (alu_req & ~reg_write) : alu_req;

    // Pipe full of loads and an ALU write waiting
    // Hold loads so the ALU write gets a gap, stores still go
    assign alu_wr_waiting = |(alu_req & reg_write);
    assign mem_req_q = (alu_wr_waiting && (&load_hist)) ? (mem_req & ~reg_write) : mem_req;

    rr_prioritizer #(
        .WIDTH(`NUM_WARPS)
    ) sched_alu (
        .clk (clk),
        .rst (rst),
        .req (alu_req_q),
        .grt (alu_grt)
    );

    rr_prioritizer #(
        .WIDTH(`NUM_WARPS)
    ) sched_mem (
        .clk (clk),
        .rst (rst),
        .req (mem_req_q),
        .grt (mem_grt)
    );

    ////////////////////////////////////////////////////////////
    // Issue registers
    ////////////////////////////////////////////////////////////

    assign alu_idx = onehot_to_idx(alu_grt);
    assign mem_idx = onehot_to_idx(mem_grt);

    always_ff @(posedge clk) begin
        if (!rst) begin
            alu_issue.valid <= 1'b0;
        end else begin
            alu_issue.valid <= |alu_grt;
        end
        alu_issue.warp      <= alu_idx;
        alu_issue.reg_write <= reg_write[alu_idx];
        alu_issue.opnd_a    <= pick_operand(opnd_a, alu_idx);
        alu_issue.opnd_b    <= pick_operand(opnd_b, alu_idx);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_issue.valid <= 1'b0;
        end else begin
            mem_issue.valid <= |mem_grt;
        end
        mem_issue.warp      <= mem_idx;
        mem_issue.reg_write <= reg_write[mem_idx];
        mem_issue.opnd_a    <= pick_operand(opnd_a, mem_idx);
        mem_issue.opnd_b    <= pick_operand(opnd_b, mem_idx);
    end

endmodule

// ==== hw/alu_pipe.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// ALU execute stage
// Register writes add, everything else is an equality branch
module alu_pipe (
    input  logic                  clk,
    input  logic                  rst,
    issue_if.executor             alu_issue,
    output logic                  res_valid,
    output issue_pkg::warp_idx_t  res_warp,
    output exec_pkg::data_t       res_data,
    output logic                  br_valid,
    output logic                  br_taken,
    output issue_pkg::warp_idx_t  br_warp
);

    logic br_issue;
    logic br_eq;

    ////////////////////////////////////////////////////////////
    // Register-write path
    ////////////////////////////////////////////////////////////

    // Sum leaves in the issue cycle
    // The CDB register in writeback is its pipeline stage
    assign res_valid = alu_issue.valid & alu_issue.reg_write;
    assign res_warp  = alu_issue.warp;

    // Carry out dropped, result wraps at DATA_W bits
    assign res_data  = alu_issue.opnd_a + alu_issue.opnd_b;

    ////////////////////////////////////////////////////////////
    // Branch path
    ////////////////////////////////////////////////////////////

    // Non-writing ALU op resolves as a branch
    assign br_issue = alu_issue.valid & ~alu_issue.reg_write;

    // BEQ style compare
    assign br_eq = (alu_issue.opnd_a == alu_issue.opnd_b);

    // Outcome registered, lines up with the CDB result timing
    always_ff @(posedge clk) begin
        if (!rst) begin
            br_valid <= 1'b0;
        end else begin
            br_valid <= br_issue;
        end
        // Payload only moves with a branch
        if (br_issue) begin
            br_warp  <= alu_issue.warp;
            br_taken <= br_eq;
        end
    end

endmodule

// ==== hw/mem_pipe.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// MEM pipe with a local scratch memory
// Stage 1 is the issue cycle, the rest is a shift chain
module mem_pipe (
    input  logic                  clk,
    input  logic                  rst,
    issue_if.executor             mem_issue,
    output logic                  res_valid,
    output issue_pkg::warp_idx_t  res_warp,
    output exec_pkg::data_t       res_data
);

    // Registers behind the issue stage
    localparam int CHAIN_LEN = `NUM_MEM_STAGES - 1;

    exec_pkg::data_t       mem [`MEM_DEPTH];
    exec_pkg::mem_addr_t   addr;
    logic                  is_load;
    logic                  is_store;
    exec_pkg::data_t       rd_data;

    // Load shift chain, entry 0 is the first stage after issue
    logic                  chain_valid [CHAIN_LEN];
    issue_pkg::warp_idx_t  chain_warp  [CHAIN_LEN];
    exec_pkg::data_t       chain_data  [CHAIN_LEN];

    // Word address in the low bits of operand A
    assign addr     = mem_issue.opnd_a[$bits(exec_pkg::mem_addr_t)-1:0];
    assign is_load  = mem_issue.valid & mem_issue.reg_write;
    assign is_store = mem_issue.valid & ~mem_issue.reg_write;

    ////////////////////////////////////////////////////////////
    // Scratch memory
    ////////////////////////////////////////////////////////////

    // Store lands at the end of its issue cycle
    // Next load already reads the new word
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (is_store) begin
            mem[addr] <= mem_issue.opnd_b;
        end
    end

    // Asynchronous read in the issue stage
    assign rd_data = mem[addr];

    ////////////////////////////////////////////////////////////
    // Load latency chain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < CHAIN_LEN; s++) begin
                chain_valid[s] <= 1'b0;
            end
        end else begin
            chain_valid[0] <= is_load;
            for (int s = 1; s < CHAIN_LEN; s++) begin
                chain_valid[s] <= chain_valid[s-1];
            end
        end
        // Warp and data ride along without reset
        chain_warp[0] <= mem_issue.warp;
        chain_data[0] <= rd_data;
        for (int s = 1; s < CHAIN_LEN; s++) begin
            chain_warp[s] <= chain_warp[s-1];
            chain_data[s] <= chain_data[s-1];
        end
    end

    // Last stage feeds writeback
    assign res_valid = chain_valid[CHAIN_LEN-1];
    assign res_warp  = chain_warp[CHAIN_LEN-1];
    assign res_data  = chain_data[CHAIN_LEN-1];

endmodule

// ==== hw/cdb_writeback.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// Common data bus register fed by the ALU and MEM results
module cdb_writeback (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alu_valid,
    input  logic                  mem_valid,
    input  issue_pkg::warp_idx_t  alu_warp,
    input  issue_pkg::warp_idx_t  mem_warp,
    input  exec_pkg::data_t       alu_data,
    input  exec_pkg::data_t       mem_data,
    output logic                  cdb_valid,
    output issue_pkg::warp_idx_t  cdb_warp,
    output exec_pkg::data_t       cdb_data
);

    issue_pkg::warp_idx_t  sel_warp;
    exec_pkg::data_t       sel_data;

    ////////////////////////////////////////////////////////////
    // Source select
    ////////////////////////////////////////////////////////////

    // Scheduler keeps the two sources apart
    // MEM first only because one side has to win the mux
    always_comb begin
        if (mem_valid) begin
            sel_warp = mem_warp;
            sel_data = mem_data;
        end else begin
            sel_warp = alu_warp;
            sel_data = alu_data;
        end
    end

    // Bus register
    always_ff @(posedge clk) begin
        if (!rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_valid | mem_valid;
        end
        // Hold the last broadcast when idle
        if (alu_valid || mem_valid) begin
            cdb_warp <= sel_warp;
            cdb_data <= sel_data;
        end
    end

endmodule

// ==== hw/warp_issue_top.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// Issue and writeback slice of the SIMT core
module warp_issue_top (
    input  logic                    clk,
    input  logic                    rst,
    input  issue_pkg::warp_mask_t   alu_req,
    input  issue_pkg::warp_mask_t   mem_req,
    input  issue_pkg::warp_mask_t   reg_write,
    input  exec_pkg::operand_bus_t  opnd_a,
    input  exec_pkg::operand_bus_t  opnd_b,
    output issue_pkg::warp_mask_t   alu_grt,
    output issue_pkg::warp_mask_t   mem_grt,
    output logic                    cdb_valid,
    output issue_pkg::warp_idx_t    cdb_warp,
    output exec_pkg::data_t         cdb_data,
    output logic                    br_valid,
    output issue_pkg::warp_idx_t    br_warp,
    output logic                    br_taken
);

    // Scheduler to pipes
    issue_if alu_issue ();
    issue_if mem_issue ();

    // Pipes to writeback
    logic                  alu_res_valid;
    issue_pkg::warp_idx_t  alu_res_warp;
    exec_pkg::data_t       alu_res_data;
    logic                  mem_res_valid;
    issue_pkg::warp_idx_t  mem_res_warp;
    exec_pkg::data_t       mem_res_data;

    ////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////

    cdb_scheduler u_sched (
        .clk       (clk),
        .rst       (rst),
        .alu_req   (alu_req),
        .mem_req   (mem_req),
        .reg_write (reg_write),
        .opnd_a    (opnd_a),
        .opnd_b    (opnd_b),
        .alu_grt   (alu_grt),
        .mem_grt   (mem_grt),
        .alu_issue (alu_issue.issuer),
        .mem_issue (mem_issue.issuer)
    );

    ////////////////////////////////////////////////////////////
    // Execute and writeback
    ////////////////////////////////////////////////////////////

    alu_pipe u_alu (
        .clk       (clk),
        .rst       (rst),
        .alu_issue (alu_issue.executor),
        .res_valid (alu_res_valid),
        .res_warp  (alu_res_warp),
        .res_data  (alu_res_data),
        .br_valid  (br_valid),
        .br_taken  (br_taken),
        .br_warp   (br_warp)
    );

    mem_pipe u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_issue (mem_issue.executor),
        .res_valid (mem_res_valid),
        .res_warp  (mem_res_warp),
        .res_data  (mem_res_data)
    );

    cdb_writeback u_wb (
        .clk       (clk),
        .rst       (rst),
        .alu_valid (alu_res_valid),
        .mem_valid (mem_res_valid),
        .alu_warp  (alu_res_warp),
        .mem_warp  (mem_res_warp),
        .alu_data  (alu_res_data),
        .mem_data  (mem_res_data),
        .cdb_valid (cdb_valid),
        .cdb_warp  (cdb_warp),
        .cdb_data  (cdb_data)
    );

endmodule

// ==== verification/warp_issue_tb.sv ====
`timescale 1ns/1ps
`include "issue_params.svh"

// Random issue traffic against a cycle model of the scheduler and pipes
module warp_issue_tb;

    localparam int NUM_CYCLES = 2000;
    // Idle cycles to flush the deepest pipe
    localparam int DRAIN      = `NUM_MEM_STAGES + 4;
    localparam int HIST_W     = `NUM_MEM_STAGES - 1;
    localparam int SLOTS      = NUM_CYCLES + DRAIN + `NUM_MEM_STAGES + 4;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 50) * 20;

    logic                    clk;
    logic                    rst;
    issue_pkg::warp_mask_t   alu_req;
    issue_pkg::warp_mask_t   mem_req;
    issue_pkg::warp_mask_t   reg_write;
    exec_pkg::operand_bus_t  opnd_a;
    exec_pkg::operand_bus_t  opnd_b;
    issue_pkg::warp_mask_t   alu_grt;
    issue_pkg::warp_mask_t   mem_grt;
    logic                    cdb_valid;
    issue_pkg::warp_idx_t    cdb_warp;
    exec_pkg::data_t         cdb_data;
    logic                    br_valid;
    issue_pkg::warp_idx_t    br_warp;
    logic                    br_taken;

    ////////////////////////////////////////////////////////////
    // Model state
    ////////////////////////////////////////////////////////////

    int                    alu_ptr;
    int                    mem_ptr;
    logic [HIST_W-1:0]     hist;
    // Load history as seen on the DUT's own MEM grants
    logic [HIST_W-1:0]     dut_hist;
    exec_pkg::data_t       model_mem   [`MEM_DEPTH];
    exec_pkg::data_t       a_slice     [`NUM_WARPS];
    exec_pkg::data_t       b_slice     [`NUM_WARPS];
    // Expected registered outputs, indexed by cycle
    logic                  exp_cdb_valid [SLOTS];
    issue_pkg::warp_idx_t  exp_cdb_warp  [SLOTS];
    exec_pkg::data_t       exp_cdb_data  [SLOTS];
    logic                  exp_br_valid  [SLOTS];
    issue_pkg::warp_idx_t  exp_br_warp   [SLOTS];
    logic                  exp_br_taken  [SLOTS];
    int                    err_count;
    int                    check_count;
    int                    masked_run;

    warp_issue_top DUT (
        .clk       (clk),
        .rst       (rst),
        .alu_req   (alu_req),
        .mem_req   (mem_req),
        .reg_write (reg_write),
        .opnd_a    (opnd_a),
        .opnd_b    (opnd_b),
        .alu_grt   (alu_grt),
        .mem_grt   (mem_grt),
        .cdb_valid (cdb_valid),
        .cdb_warp  (cdb_warp),
        .cdb_data  (cdb_data),
        .br_valid  (br_valid),
        .br_warp   (br_warp),
        .br_taken  (br_taken)
    );

    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_mask(input string name, input issue_pkg::warp_mask_t got,
                              input issue_pkg::warp_mask_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_idx(input string name, input issue_pkg::warp_idx_t got,
                             input issue_pkg::warp_idx_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input exec_pkg::data_t got,
                              input exec_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Rule violations that are not a single wrong value
    task automatic report(input string what);
        err_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and model helpers
    ////////////////////////////////////////////////////////////

    // First requesting warp at or after the pointer, -1 when none
    function automatic int rr_pick(input issue_pkg::warp_mask_t req, input int ptr);
        int w;
        for (int k = 0; k < `NUM_WARPS; k++) begin
            w = (ptr + k) % `NUM_WARPS;
            if (req[w]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic drive_random();
        exec_pkg::mem_addr_t addr;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            // Mostly words 0 to 2, so loads hit earlier stores
            if ($urandom_range(7) == 0) begin
                addr = exec_pkg::mem_addr_t'($urandom);
            end else begin
                addr = exec_pkg::mem_addr_t'($urandom_range(2));
            end
            a_slice[w] = exec_pkg::data_t'($urandom);
            a_slice[w][$bits(exec_pkg::mem_addr_t)-1:0] = addr;
            // Equal operands now and then for taken branches
            b_slice[w] = ($urandom_range(3) == 0) ? a_slice[w] : exec_pkg::data_t'($urandom);
            opnd_a[w*`DATA_W +: `DATA_W] = a_slice[w];
            opnd_b[w*`DATA_W +: `DATA_W] = b_slice[w];
        end
        alu_req   = issue_pkg::warp_mask_t'($urandom);
        mem_req   = issue_pkg::warp_mask_t'($urandom);
        // Writes weighted to 3 in 4 so the load history fills up
        reg_write = issue_pkg::warp_mask_t'($urandom) | issue_pkg::warp_mask_t'($urandom);
    endtask

    task automatic drive_idle();
        alu_req   = '0;
        mem_req   = '0;
        reg_write = '0;
        opnd_a    = '0;
        opnd_b    = '0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            a_slice[w] = '0;
            b_slice[w] = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One clock cycle: drive, check, advance model
    ////////////////////////////////////////////////////////////

    task automatic run_cycle(input int cyc, input bit active);
        issue_pkg::warp_mask_t alu_q;
        issue_pkg::warp_mask_t mem_q;
        issue_pkg::warp_mask_t exp_alu;
        issue_pkg::warp_mask_t exp_mem;
        exec_pkg::mem_addr_t   addr;
        int                    ga;
        int                    gm;
        int                    s;
        logic                  alu_wr_wait;
        logic                  load_now;
        @(posedge clk);
        #2;
        if (active) begin
            drive_random();
        end else begin
            drive_idle();
        end
        // Qualification against the load history
        alu_wr_wait = |(alu_req & reg_write);
        alu_q = hist[HIST_W-1] ? (alu_req & ~reg_write) : alu_req;
        mem_q = (alu_wr_wait && (&hist)) ? (mem_req & ~reg_write) : mem_req;
        ga = rr_pick(alu_q, alu_ptr);
        gm = rr_pick(mem_q, mem_ptr);
        exp_alu = '0;
        exp_mem = '0;
        if (ga >= 0) exp_alu[ga] = 1'b1;
        if (gm >= 0) exp_mem[gm] = 1'b1;
        // Sample 8 ns after the edge
        #6;
        check_mask("alu_grt", alu_grt, exp_alu);
        check_mask("mem_grt", mem_grt, exp_mem);
        if ((alu_grt & (alu_grt - 1'b1)) != 0 || (mem_grt & (mem_grt - 1'b1)) != 0) begin
            report("a grant has more than one bit set");
        end
        if (hist[HIST_W-1] && |(alu_grt & reg_write)) begin
            report("ALU register write granted into the CDB slot of an older load");
        end
        if (alu_wr_wait && (&hist) && |(mem_grt & reg_write)) begin
            report("load granted while an ALU write waits behind a full load history");
        end
        // ALU writes must not be held off longer than the history depth
        if (alu_wr_wait && dut_hist[HIST_W-1]) begin
            masked_run++;
            if (masked_run > HIST_W) begin
                report("ALU register writes held off by loads for too long");
            end
        end else begin
            masked_run = 0;
        end
        check_bit("cdb_valid", cdb_valid, exp_cdb_valid[cyc]);
        if (exp_cdb_valid[cyc]) begin
            check_idx("cdb_warp", cdb_warp, exp_cdb_warp[cyc]);
            check_data("cdb_data", cdb_data, exp_cdb_data[cyc]);
        end
        check_bit("br_valid", br_valid, exp_br_valid[cyc]);
        if (exp_br_valid[cyc]) begin
            check_idx("br_warp", br_warp, exp_br_warp[cyc]);
            check_bit("br_taken", br_taken, exp_br_taken[cyc]);
        end
        // ALU result or branch two cycles out
        if (ga >= 0) begin
            alu_ptr = (ga + 1) % `NUM_WARPS;
            s = cyc + 2;
            if (reg_write[ga]) begin
                exp_cdb_valid[s] = 1'b1;
                exp_cdb_warp[s]  = issue_pkg::warp_idx_t'(ga);
                exp_cdb_data[s]  = a_slice[ga] + b_slice[ga];
            end else begin
                exp_br_valid[s] = 1'b1;
                exp_br_warp[s]  = issue_pkg::warp_idx_t'(ga);
                exp_br_taken[s] = (a_slice[ga] == b_slice[ga]);
            end
        end
        // MEM ops apply to the image in grant order
        load_now = 1'b0;
        if (gm >= 0) begin
            mem_ptr  = (gm + 1) % `NUM_WARPS;
            addr     = a_slice[gm][$bits(exec_pkg::mem_addr_t)-1:0];
            load_now = reg_write[gm];
            s = cyc + `NUM_MEM_STAGES + 1;
            if (load_now) begin
                exp_cdb_valid[s] = 1'b1;
                exp_cdb_warp[s]  = issue_pkg::warp_idx_t'(gm);
                exp_cdb_data[s]  = model_mem[addr];
            end else begin
                model_mem[addr] = b_slice[gm];
            end
        end
        hist = {hist[HIST_W-2:0], load_now};
        dut_hist = {dut_hist[HIST_W-2:0], |(mem_grt & reg_write)};
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h1d22fe2d));
        err_count   = 0;
        check_count = 0;
        masked_run  = 0;
        alu_ptr     = 0;
        mem_ptr     = 0;
        hist        = '0;
        dut_hist    = '0;
        rst         = 1'b0;
        drive_idle();
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < SLOTS; i++) begin
            exp_cdb_valid[i] = 1'b0;
            exp_br_valid[i]  = 1'b0;
        end
        // Reset for 4 cycles
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES + DRAIN; cyc++) begin
            run_cycle(cyc, cyc < NUM_CYCLES);
        end
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== warp_issue_top.f ====
+incdir+hw
hw/issue_pkg.sv
hw/exec_pkg.sv
hw/issue_if.sv
hw/rr_prioritizer.sv
hw/cdb_scheduler.sv
hw/alu_pipe.sv
hw/mem_pipe.sv
hw/cdb_writeback.sv
hw/warp_issue_top.sv
verification/warp_issue_tb.sv
